// File: Bender.yml
package:
  name: gauss_step

sources:
  # synthesizable design, package first
  - design/gauss_pkg.sv
  - design/line_ram.sv
  - design/elim_cell.sv
  - design/elim_line.sv
  - design/step_ctrl.sv
  - design/gauss_step_top.sv

  # testbench and bound assertions
  - target: simulation
    files:
      - sim/gauss_step_sva.sv
      - sim/tb_gauss_step.sv

// File: build.f
design/gauss_pkg.sv
design/line_ram.sv
design/elim_cell.sv
design/elim_line.sv
design/step_ctrl.sv
design/gauss_step_top.sv
sim/gauss_step_sva.sv
sim/tb_gauss_step.sv

// File: design/elim_cell.sv
//**************************************************************************
// systolic elimination cell
// holds one pivot row, captures, xors or passes each row in one stage
//**************************************************************************
`timescale 1ns/1ps
`default_nettype none

module elim_cell import gauss_pkg::*; #(
  parameter int N     = 4,
  parameter int INDEX = 0
) (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           clear,
  input  mode_e          mode,
  input  logic           in_valid,
  input  logic [N-1:0]   in_row,
  input  logic           in_drop,
  input  logic [2*N-1:0] in_ops,
  output logic           out_valid,
  output logic [N-1:0]   out_row,
  output logic           out_drop,
  output logic [2*N-1:0] out_ops,
  output logic [N-1:0]   pivot,
  output logic           has_pivot
);

  op_e            field;
  op_e            act;
  logic [N-1:0]   row_next;
  logic [2*N-1:0] ops_next;

  always_comb begin
    field = op_e'(in_ops[2*INDEX +: 2]);
    if (in_drop) begin
      act = op_pass;  // already a pivot upstream
    end else if (mode == mode_eliminate) begin
      if (in_row[INDEX] && !has_pivot)
        act = op_capture;
      else if (in_row[INDEX])
        act = op_xor;
      else
        act = op_pass;
    end else begin
      act = field;  // replay recorded op
    end
    row_next = (act == op_xor) ? (in_row ^ pivot) : in_row;
    ops_next = in_ops;
    ops_next[2*INDEX +: 2] = act;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
      has_pivot <= 1'b0;
    end else begin
      out_valid <= in_valid;
      if (clear)
        has_pivot <= 1'b0;
      else if (in_valid && act == op_capture)
        has_pivot <= 1'b1;
    end
  end

  // payload stage
  always_ff @(posedge clk) begin
    if (in_valid && act == op_capture) pivot <= in_row;
    out_row  <= row_next;
    out_drop <= in_drop || (act == op_capture);
    out_ops  <= ops_next;
  end

endmodule

`default_nettype wire

// File: design/elim_line.sv
//**************************************************************************
// systolic elimination line
// N cells in series, row and op word advance one cell per cycle
//**************************************************************************
`timescale 1ns/1ps
`default_nettype none

module elim_line import gauss_pkg::*; #(
  parameter int N = 4
) (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           clear,
  input  mode_e          mode,
  input  logic           in_valid,
  input  logic [N-1:0]   in_row,
  input  logic [2*N-1:0] in_ops,
  output logic           out_valid,
  output logic [N-1:0]   out_row,
  output logic           out_drop,
  output logic [2*N-1:0] out_ops,
  output logic [N*N-1:0] pivot_bus,
  output logic           full_rank
);

  logic [N:0]                valid_c;
  logic [N:0]                drop_c;
  logic [N:0][N-1:0]         row_c;
  logic [N:0][2*N-1:0]       ops_c;
  logic [N-1:0][N-1:0]       piv;
  logic [N-1:0]              has_piv;

  assign valid_c[0] = in_valid;
  assign row_c[0]   = in_row;
  assign drop_c[0]  = 1'b0;  // nothing dropped on entry
  assign ops_c[0]   = (mode == mode_apply) ? in_ops : '0;

  for (genvar j = 0; j < N; j++) begin : g_cell
    elim_cell #(.N(N), .INDEX(j)) i_elim_cell (
      .clk       (clk),
      .rst_n     (rst_n),
      .clear     (clear),
      .mode      (mode),
      .in_valid  (valid_c[j]),
      .in_row    (row_c[j]),
      .in_drop   (drop_c[j]),
      .in_ops    (ops_c[j]),
      .out_valid (valid_c[j+1]),
      .out_row   (row_c[j+1]),
      .out_drop  (drop_c[j+1]),
      .out_ops   (ops_c[j+1]),
      .pivot     (piv[j]),
      .has_pivot (has_piv[j])
    );
    assign pivot_bus[j*N +: N] = has_piv[j] ? piv[j] : '0;  // empty cell reads zero
  end

  assign out_valid = valid_c[N];
  assign out_row   = row_c[N];
  assign out_drop  = drop_c[N];
  assign out_ops   = ops_c[N];
  assign full_rank = &has_piv;

endmodule

`default_nettype wire

// File: design/gauss_pkg.sv
//**************************************************************************
// gauss step shared types
// cell opcodes, step mode and sequencer states for the GF(2) eliminator
//**************************************************************************
`default_nettype none

package gauss_pkg;

  // action of one cell on one row, one field per cell in an op word
  typedef enum logic [1:0] {
    op_pass    = 2'd0,  // row goes on unchanged
    op_xor     = 2'd1,  // row ^= pivot
    op_capture = 2'd2   // row becomes the pivot, dropped from stream
  } op_e;

  typedef enum logic {
    mode_eliminate = 1'b0,
    mode_apply     = 1'b1
  } mode_e;

  typedef enum logic [1:0] {
    st_idle,
    st_stream,
    st_drain,
    st_pivots
  } step_state_e;

endpackage

`default_nettype wire

// File: design/gauss_step_top.sv
//**************************************************************************
// GF(2) gaussian elimination step
// sequencer, data and op RAMs and the systolic line
//**************************************************************************
`timescale 1ns/1ps
`default_nettype none

module gauss_step_top import gauss_pkg::*; #(
  parameter int N = 4,
  parameter int L = 8,
  parameter int K = 16,
  localparam int AW  = $clog2(L*K/N),
  localparam int OAW = (L > 1) ? $clog2(L) : 1,
  localparam int BW  = (K/N > 1) ? $clog2(K/N) : 1
) (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          start,
  input  mode_e         mode,
  input  logic [BW-1:0] col_block,
  input  logic          wr_en,
  input  logic [AW-1:0] wr_addr,
  input  logic [N-1:0]  data_in,
  input  logic          rd_en,
  input  logic [AW-1:0] rd_addr,
  output logic [N-1:0]  data_out,
  output logic          busy,
  output logic          done,
  output logic          fail
);

  logic           data_wr_en, data_rd_en;
  logic [AW-1:0]  data_wr_addr, data_rd_addr;
  logic [N-1:0]   data_wr_data;
  logic           op_wr_en, op_rd_en;
  logic [OAW-1:0] op_wr_addr, op_rd_addr;
  logic [2*N-1:0] op_wr_data, op_rd_data;
  logic           line_clear, line_valid;
  mode_e          line_mode;
  logic           line_out_valid, line_out_drop, full_rank;
  logic [N-1:0]   line_out_row;
  logic [2*N-1:0] line_out_ops;
  logic [N*N-1:0] pivot_bus;

  step_ctrl #(.N(N), .L(L), .K(K)) i_step_ctrl (
    .clk (clk), .rst_n (rst_n), .start (start), .mode (mode), .col_block (col_block),
    .ext_wr_en (wr_en), .ext_wr_addr (wr_addr), .ext_wr_data (data_in),
    .ext_rd_en (rd_en), .ext_rd_addr (rd_addr),
    .data_wr_en (data_wr_en), .data_wr_addr (data_wr_addr), .data_wr_data (data_wr_data),
    .data_rd_en (data_rd_en), .data_rd_addr (data_rd_addr),
    .op_wr_en (op_wr_en), .op_wr_addr (op_wr_addr), .op_wr_data (op_wr_data),
    .op_rd_en (op_rd_en), .op_rd_addr (op_rd_addr),
    .line_clear (line_clear), .line_mode (line_mode), .line_valid (line_valid),
    .line_out_valid (line_out_valid), .line_out_row (line_out_row),
    .line_out_drop (line_out_drop), .line_out_ops (line_out_ops),
    .pivot_bus (pivot_bus), .full_rank (full_rank),
    .busy (busy), .done (done), .fail (fail)
  );

  line_ram #(.WIDTH(N), .DEPTH(L*K/N)) data_ram (
    .clk (clk), .wr_en (data_wr_en), .wr_addr (data_wr_addr), .wr_data (data_wr_data),
    .rd_en (data_rd_en), .rd_addr (data_rd_addr), .rd_data (data_out)
  );

  line_ram #(.WIDTH(2*N), .DEPTH(L)) op_ram (
    .clk (clk), .wr_en (op_wr_en), .wr_addr (op_wr_addr), .wr_data (op_wr_data),
    .rd_en (op_rd_en), .rd_addr (op_rd_addr), .rd_data (op_rd_data)
  );

  elim_line #(.N(N)) i_elim_line (
    .clk (clk), .rst_n (rst_n), .clear (line_clear), .mode (line_mode),
    .in_valid (line_valid), .in_row (data_out), .in_ops (op_rd_data),
    .out_valid (line_out_valid), .out_row (line_out_row), .out_drop (line_out_drop),
    .out_ops (line_out_ops), .pivot_bus (pivot_bus), .full_rank (full_rank)
  );

endmodule

`default_nettype wire

// File: design/line_ram.sv
//**************************************************************************
// simple dual-port RAM
// one write port, one read port with registered output held on idle
//**************************************************************************
`timescale 1ns/1ps
`default_nettype none

module line_ram #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 16,
  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
  input  logic             clk,
  input  logic             wr_en,
  input  logic [AW-1:0]    wr_addr,
  input  logic [WIDTH-1:0] wr_data,
  input  logic             rd_en,
  input  logic [AW-1:0]    rd_addr,
  output logic [WIDTH-1:0] rd_data
);

  logic [WIDTH-1:0] mem [DEPTH];

  always_ff @(posedge clk) begin
    if (wr_en) mem[wr_addr] <= wr_data;
    if (rd_en) rd_data <= mem[rd_addr];  // old data on same-address collision
  end

endmodule

`default_nettype wire

// File: design/step_ctrl.sv
//**************************************************************************
// elimination step sequencer
// streams one block through the line, writes back remainders and pivots
//**************************************************************************
`timescale 1ns/1ps
`default_nettype none

module step_ctrl import gauss_pkg::*; #(
  parameter int N = 4,
  parameter int L = 8,
  parameter int K = 16,
  localparam int AW  = $clog2(L*K/N),
  localparam int OAW = (L > 1) ? $clog2(L) : 1,
  localparam int BW  = (K/N > 1) ? $clog2(K/N) : 1
) (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           start,
  input  mode_e          mode,
  input  logic [BW-1:0]  col_block,
  input  logic           ext_wr_en,
  input  logic [AW-1:0]  ext_wr_addr,
  input  logic [N-1:0]   ext_wr_data,
  input  logic           ext_rd_en,
  input  logic [AW-1:0]  ext_rd_addr,
  output logic           data_wr_en,
  output logic [AW-1:0]  data_wr_addr,
  output logic [N-1:0]   data_wr_data,
  output logic           data_rd_en,
  output logic [AW-1:0]  data_rd_addr,
  output logic           op_wr_en,
  output logic [OAW-1:0] op_wr_addr,
  output logic [2*N-1:0] op_wr_data,
  output logic           op_rd_en,
  output logic [OAW-1:0] op_rd_addr,
  output logic           line_clear,
  output mode_e          line_mode,
  output logic           line_valid,
  input  logic           line_out_valid,
  input  logic [N-1:0]   line_out_row,
  input  logic           line_out_drop,
  input  logic [2*N-1:0] line_out_ops,
  input  logic [N*N-1:0] pivot_bus,
  input  logic           full_rank,
  output logic           busy,
  output logic           done,
  output logic           fail
);

  localparam int CW = $clog2(L + N + 2);
  localparam int RW = $clog2(L + 1);

  step_state_e    state;
  logic [CW-1:0]  cnt;
  logic           arm;       // setup cycle after an accepted start
  logic           start_ok;
  mode_e          mode_q;
  logic [AW-1:0]  base;      // block start address
  logic           rd_valid;
  logic [OAW-1:0] out_idx;
  logic [RW-1:0]  rem_off;
  logic           last_pivot;
  logic           rem_wr;
  logic           piv_wr;
  logic [N-1:0]   piv_sel;
  logic           ctrl_wr_en;
  logic [AW-1:0]  ctrl_wr_addr;
  logic [N-1:0]   ctrl_wr_data;
  logic           ctrl_rd_en;
  logic [AW-1:0]  ctrl_rd_addr;

  assign start_ok   = start && (state == st_idle) && !arm;
  assign busy       = (state != st_idle) || arm;
  assign last_pivot = (state == st_pivots) && (cnt == CW'(N - 1));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= st_idle;
      cnt      <= '0;
      arm      <= 1'b0;
      mode_q   <= mode_eliminate;
      rd_valid <= 1'b0;
      done     <= 1'b0;
      fail     <= 1'b0;
    end else begin
      arm      <= start_ok;
      rd_valid <= (state == st_stream);  // RAM data arrives one cycle later
      done     <= last_pivot;
      if (start_ok) begin
        mode_q <= mode;
        fail   <= 1'b0;
      end else if (last_pivot) begin
        fail <= (mode_q == mode_eliminate) && !full_rank;
      end
      case (state)
        st_idle:
          if (arm) begin
            state <= st_stream;
            cnt   <= '0;
          end
        st_stream:
          if (cnt == CW'(L - 1)) begin
            state <= st_drain;
            cnt   <= '0;
          end else cnt <= cnt + 1'b1;
        st_drain:  // read latency plus line depth
          if (cnt == CW'(N)) begin
            state <= st_pivots;
            cnt   <= '0;
          end else cnt <= cnt + 1'b1;
        st_pivots:
          if (last_pivot) begin
            state <= st_idle;
            cnt   <= '0;
          end else cnt <= cnt + 1'b1;
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (start_ok) base <= AW'(col_block * L);
  end

  // output row index and remainder offset, both counted at line exit
  always_ff @(posedge clk) begin
    if (!rst_n || arm) begin
      out_idx <= '0;
      rem_off <= RW'(N);
    end else if (line_out_valid) begin
      out_idx <= out_idx + 1'b1;
      if (rem_wr) rem_off <= rem_off + 1'b1;
    end
  end

  assign rem_wr  = line_out_valid && !line_out_drop && (rem_off < RW'(L));
  assign piv_wr  = (state == st_pivots);
  assign piv_sel = pivot_bus[cnt*N +: N];

  assign ctrl_wr_en   = rem_wr || piv_wr;
  assign ctrl_wr_addr = piv_wr ? base + AW'(cnt) : base + AW'(rem_off);
  assign ctrl_wr_data = piv_wr ? piv_sel : line_out_row;
  assign ctrl_rd_en   = (state == st_stream);
  assign ctrl_rd_addr = base + AW'(cnt);

  // external port wins the data RAM
  assign data_wr_en   = ext_wr_en || ctrl_wr_en;
  assign data_wr_addr = ext_wr_en ? ext_wr_addr : ctrl_wr_addr;
  assign data_wr_data = ext_wr_en ? ext_wr_data : ctrl_wr_data;
  assign data_rd_en   = ext_rd_en || ctrl_rd_en;
  assign data_rd_addr = ext_rd_en ? ext_rd_addr : ctrl_rd_addr;

  assign op_wr_en   = line_out_valid && (mode_q == mode_eliminate);
  assign op_wr_addr = out_idx;
  assign op_wr_data = line_out_ops;
  assign op_rd_en   = ctrl_rd_en && (mode_q == mode_apply);  // in step with data reads
  assign op_rd_addr = OAW'(cnt);

  assign line_clear = arm;
  assign line_mode  = mode_q;
  assign line_valid = rd_valid;

endmodule

`default_nettype wire

// File: sim/gauss_step_sva.sv
//**************************************************************************
// step sequencer assertions
// done pulse width, start while busy, data RAM port priority, fail updates
//**************************************************************************
`timescale 1ns/1ps
`default_nettype none

module gauss_step_sva (
  input logic clk,
  input logic rst_n,
  input logic start,
  input logic line_clear,
  input logic done,
  input logic fail,
  input logic ext_wr_en,
  input logic ctrl_wr_en
);

  logic in_step;  // from the line clear of a step to its done

  always_ff @(posedge clk) begin
    if (!rst_n)
      in_step <= 1'b0;
    else if (line_clear)
      in_step <= 1'b1;
    else if (done)
      in_step <= 1'b0;
  end

  done_pulse: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
    else $error("done held high for more than one cycle");

  // a start seen while busy must not clear the line of the running step
  start_ignored: assert property (@(posedge clk) disable iff (!rst_n)
    line_clear |-> !in_step)
    else $error("start accepted while busy");

  ext_priority: assert property (@(posedge clk) disable iff (!rst_n)
    ext_wr_en |-> !ctrl_wr_en)
    else $error("controller wrote the data RAM during an external write");

  fail_update: assert property (@(posedge clk) disable iff (!rst_n)
    !$stable(fail) |-> (done || $past(start)))
    else $error("fail changed outside start or done");

endmodule

bind step_ctrl gauss_step_sva i_gauss_step_sva (
  .clk        (clk),
  .rst_n      (rst_n),
  .start      (start),
  .line_clear (line_clear),
  .done       (done),
  .fail       (fail),
  .ext_wr_en  (ext_wr_en),
  .ctrl_wr_en (ctrl_wr_en)
);

`default_nettype wire

// File: sim/tb_gauss_step.sv
//**************************************************************************
// testbench for the GF(2) elimination step
// random blocks run through eliminate and apply, checked against a model
//**************************************************************************
`timescale 1ns/1ps
`default_nettype none

module tb_gauss_step import gauss_pkg::*; ();

  localparam int N        = 4;
  localparam int L        = 8;
  localparam int K        = 16;
  localparam int NB       = K/N;
  localparam int AW       = $clog2(L*K/N);
  localparam int BW       = $clog2(K/N);
  localparam int STEP_CYC = L + 2*N + 3;
  localparam int STEPS    = 6;
  localparam int WORDS    = 144;  // loads, readbacks and random port traffic
  localparam int LIMIT    = STEPS*STEP_CYC + 2*WORDS + 200;

  logic          clk;
  logic          rst_n;
  logic          start;
  mode_e         mode;
  logic [BW-1:0] col_block;
  logic          wr_en;
  logic [AW-1:0] wr_addr;
  logic [N-1:0]  data_in;
  logic          rd_en;
  logic [AW-1:0] rd_addr;
  logic [N-1:0]  data_out;
  logic          busy;
  logic          done;
  logic          fail;

  logic [N-1:0]   mem_m [L*NB];  // data RAM as the model sees it
  logic [2*N-1:0] ops_m [L];     // op words of the last eliminate step
  logic           fail_m;
  integer         seed = 21;
  int             cyc = 0;
  int             err_count = 0;

  gauss_step_top #(.N(N), .L(L), .K(K)) i_gauss_step_top (
    .clk (clk), .rst_n (rst_n), .start (start), .mode (mode), .col_block (col_block),
    .wr_en (wr_en), .wr_addr (wr_addr), .data_in (data_in),
    .rd_en (rd_en), .rd_addr (rd_addr), .data_out (data_out),
    .busy (busy), .done (done), .fail (fail)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc > LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", LIMIT);
      $display("FAIL: see errors above");
      $fatal(1, "simulation timed out");
    end
  end

  task automatic report_error(input string msg);
    err_count++;
    $display("[ERROR] %0t: %s", $time, msg);
    $display("FAIL: see errors above");
    $fatal(1, "check failed");
  endtask

  task automatic check_word(input logic [AW-1:0] addr, input logic [N-1:0] got,
                            input logic [N-1:0] exp);
    if (got !== exp)
      report_error($sformatf("word at 0x%0h is 0x%0h, expected 0x%0h", addr, got, exp));
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp)
      report_error($sformatf("%s is %b, expected %b", what, got, exp));
  endtask

  task automatic check_done(input int cycles);
    if (cycles != STEP_CYC)
      report_error($sformatf("done after %0d cycles, expected %0d", cycles, STEP_CYC));
  endtask

  // each row walks the software cells 0..N-1 in order
  task automatic model_step(input mode_e m, input int blk);
    logic [N-1:0] piv [N];
    logic [N-1:0] has;
    logic [N-1:0] blk_out [L];
    logic [N-1:0] row;
    logic         drop;
    op_e          op;
    int           off;
    has = '0;
    off = N;  // remainders land after the pivots
    for (int r = 0; r < L; r++) blk_out[r] = mem_m[blk*L + r];
    for (int r = 0; r < L; r++) begin
      row  = mem_m[blk*L + r];
      drop = 1'b0;
      for (int j = 0; j < N; j++) begin
        if (drop) op = op_pass;
        else if (m == mode_apply) op = op_e'(ops_m[r][2*j +: 2]);
        else if (row[j] && !has[j]) op = op_capture;
        else if (row[j]) op = op_xor;
        else op = op_pass;
        if (m == mode_eliminate) ops_m[r][2*j +: 2] = op;
        if (op == op_xor) row = row ^ piv[j];
        if (op == op_capture) begin
          piv[j] = row;
          has[j] = 1'b1;
          drop   = 1'b1;
        end
      end
      if (!drop && off < L) begin
        blk_out[off] = row;
        off++;
      end
    end
    for (int j = 0; j < N; j++) blk_out[j] = has[j] ? piv[j] : '0;
    for (int r = 0; r < L; r++) mem_m[blk*L + r] = blk_out[r];
    fail_m = (m == mode_eliminate) && !(&has);
  endtask

  // port tasks start and end on a falling edge
  task automatic write_word(input logic [AW-1:0] addr, input logic [N-1:0] data);
    wr_en   = 1'b1;
    wr_addr = addr;
    data_in = data;
    mem_m[addr] = data;
    @(negedge clk);
    wr_en = 1'b0;
  endtask

  task automatic read_word(input logic [AW-1:0] addr);
    rd_en   = 1'b1;
    rd_addr = addr;
    @(negedge clk);
    rd_en = 1'b0;
    check_word(addr, data_out, mem_m[addr]);
  endtask

  task automatic read_block(input int blk);
    for (int r = 0; r < L; r++) read_word(AW'(blk*L + r));
  endtask

  task automatic run_step(input mode_e m, input int blk, input bit extra_start);
    int t0;
    model_step(m, blk);
    start     = 1'b1;
    mode      = m;
    col_block = BW'(blk);
    t0        = cyc;
    @(negedge clk);
    start = 1'b0;
    check_flag(fail, 1'b0, "fail after start");
    while (!done) begin
      start = extra_start && (cyc == t0 + 6);  // stray pulse mid step
      @(negedge clk);
    end
    check_done(cyc - t0);
    check_flag(fail, fail_m, "fail after done");
    repeat (3) begin
      @(negedge clk);
      check_flag(busy, 1'b0, "busy after done");
    end
  endtask

  initial begin
    int            zc;
    logic [N-1:0]  row;
    logic [AW-1:0] addr;
    rst_n     = 1'b0;
    start     = 1'b0;
    mode      = mode_eliminate;
    col_block = '0;
    wr_en     = 1'b0;
    wr_addr   = '0;
    data_in   = '0;
    rd_en     = 1'b0;
    rd_addr   = '0;
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    // whole RAM random, top rows of block 0 triangular with unit diagonal
    for (int a = 0; a < L*NB; a++) begin
      row = N'($random(seed));
      if (a < N) begin
        row    = row & ~((N'(1) << a) - N'(1));
        row[a] = 1'b1;
      end
      write_word(AW'(a), row);
    end
    run_step(mode_eliminate, 0, 1'b0);
    read_block(0);
    for (int b = 1; b < NB; b++) begin
      run_step(mode_apply, b, 1'b0);
      read_block(b);
    end

    // block 0 made rank deficient by one all-zero column
    zc = $unsigned($random(seed)) % N;
    for (int r = 0; r < L; r++) begin
      row     = N'($random(seed));
      row[zc] = 1'b0;
      write_word(AW'(r), row);
    end
    run_step(mode_eliminate, 0, 1'b0);
    check_flag(fail, 1'b1, "fail on zero column");
    read_block(0);
    read_block(1);  // nothing spilled past the block
    run_step(mode_apply, 2, 1'b1);
    read_block(2);

    // port traffic between steps
    for (int i = 0; i < 16; i++) begin
      addr = AW'($random(seed));
      write_word(addr, N'($random(seed)));
      read_word(addr);
      read_word(AW'($random(seed)));
    end

    if (err_count == 0) begin
      $display("PASS: all tests");
      $finish;
    end else begin
      $display("FAIL: see errors above");
      $fatal(1, "errors found");
    end
  end

endmodule

`default_nettype wire
